//--- hdl/kbd_keymap_pkg.sv
//********************************************************************
// keymap definitions for the ps/2 to pc-8001 key matrix converter
// scan code, matrix row and column types, set-2 make codes
//********************************************************************
`default_nettype none

package kbd_keymap_pkg;

   typedef logic [7:0] scan_code_t;   // one ps/2 byte
   typedef logic [3:0] kbd_row_t;     // matrix row 0..9
   typedef logic [7:0] kbd_mask_t;    // one-hot column within a row

   // one key position in the matrix
   typedef struct packed {
      kbd_row_t  row;
      kbd_mask_t mask;
   } key_entry_t;

   localparam int         NUM_ROWS   = 10;
   localparam kbd_row_t   ROW_SHIFT  = 4'd8;
   localparam kbd_mask_t  MASK_SHIFT = 8'h40;

   localparam scan_code_t CODE_BREAK = 8'hF0;   // break prefix
   localparam scan_code_t CODE_SHIFT = 8'h12;   // left shift only

   //*****************************************************************
   // make codes, grouped by matrix row
   //*****************************************************************
   localparam scan_code_t CODE_ENTER     = 8'h5A;   // row 1
   localparam scan_code_t CODE_AT        = 8'h54;   // row 2
   localparam scan_code_t CODE_A         = 8'h1C;
   localparam scan_code_t CODE_B         = 8'h32;
   localparam scan_code_t CODE_C         = 8'h21;
   localparam scan_code_t CODE_D         = 8'h23;
   localparam scan_code_t CODE_E         = 8'h24;
   localparam scan_code_t CODE_F         = 8'h2B;
   localparam scan_code_t CODE_G         = 8'h34;
   localparam scan_code_t CODE_H         = 8'h33;   // row 3
   localparam scan_code_t CODE_I         = 8'h43;
   localparam scan_code_t CODE_J         = 8'h3B;
   localparam scan_code_t CODE_K         = 8'h42;
   localparam scan_code_t CODE_L         = 8'h4B;
   localparam scan_code_t CODE_M         = 8'h3A;
   localparam scan_code_t CODE_N         = 8'h31;
   localparam scan_code_t CODE_O         = 8'h44;
   localparam scan_code_t CODE_P         = 8'h4D;   // row 4
   localparam scan_code_t CODE_Q         = 8'h15;
   localparam scan_code_t CODE_R         = 8'h2D;
   localparam scan_code_t CODE_S         = 8'h1B;
   localparam scan_code_t CODE_T         = 8'h2C;
   localparam scan_code_t CODE_U         = 8'h3C;
   localparam scan_code_t CODE_V         = 8'h2A;
   localparam scan_code_t CODE_W         = 8'h1D;
   localparam scan_code_t CODE_X         = 8'h22;   // row 5
   localparam scan_code_t CODE_Y         = 8'h35;
   localparam scan_code_t CODE_Z         = 8'h1A;
   localparam scan_code_t CODE_LBRACKET  = 8'h5B;
   localparam scan_code_t CODE_YEN       = 8'h6A;
   localparam scan_code_t CODE_RBRACKET  = 8'h5D;
   localparam scan_code_t CODE_CARET     = 8'h55;
   localparam scan_code_t CODE_MINUS     = 8'h4E;
   localparam scan_code_t CODE_0         = 8'h45;   // row 6
   localparam scan_code_t CODE_1         = 8'h16;
   localparam scan_code_t CODE_2         = 8'h1E;
   localparam scan_code_t CODE_3         = 8'h26;
   localparam scan_code_t CODE_4         = 8'h25;
   localparam scan_code_t CODE_5         = 8'h2E;
   localparam scan_code_t CODE_6         = 8'h36;
   localparam scan_code_t CODE_7         = 8'h3D;
   localparam scan_code_t CODE_8         = 8'h3E;   // row 7
   localparam scan_code_t CODE_9         = 8'h46;
   localparam scan_code_t CODE_COLON     = 8'h52;
   localparam scan_code_t CODE_SEMICOLON = 8'h4C;
   localparam scan_code_t CODE_COMMA     = 8'h41;
   localparam scan_code_t CODE_PERIOD    = 8'h49;
   localparam scan_code_t CODE_SLASH     = 8'h4A;
   localparam scan_code_t CODE_HOME      = 8'h6C;   // row 8, shift sits at bit 6
   localparam scan_code_t CODE_DOWN      = 8'h72;
   localparam scan_code_t CODE_LEFT      = 8'h6B;
   localparam scan_code_t CODE_INS       = 8'h70;
   localparam scan_code_t CODE_KANA      = 8'h13;
   localparam scan_code_t CODE_CTRL      = 8'h14;
   localparam scan_code_t CODE_STOP      = 8'h77;   // row 9
   localparam scan_code_t CODE_F1        = 8'h05;
   localparam scan_code_t CODE_F2        = 8'h06;
   localparam scan_code_t CODE_F3        = 8'h04;
   localparam scan_code_t CODE_F4        = 8'h0C;
   localparam scan_code_t CODE_F5        = 8'h03;
   localparam scan_code_t CODE_SPACE     = 8'h29;
   localparam scan_code_t CODE_ESC       = 8'h76;

endpackage

`default_nettype wire

//--- hdl/kbd_bus_pkg.sv
//********************************************************************
// cpu side definitions for the key matrix port
// port 00h read bundle, read data, read sequencing constants
//********************************************************************
`default_nettype none

package kbd_bus_pkg;

   typedef logic [3:0] cpu_addr_t;    // low port address, selects row
   typedef logic [7:0] kbd_data_t;    // matrix read data
   typedef logic [3:0] read_cnt_t;    // reads seen for the held key

   // cpu read request, iorq is asynchronous to the keyboard clock
   typedef struct packed {
      logic      iorq;
      logic      port00h;
      cpu_addr_t addr;
   } cpu_read_t;

   // reads that still see the held key, the next one releases it
   localparam int HELD_READS = 14;

endpackage

`default_nettype wire

//--- hdl/kbd_keymap_decoder.sv
//********************************************************************
// keymap decoder
// maps a set-2 make code to a matrix row and one-hot column mask
//********************************************************************
`default_nettype none

module kbd_keymap_decoder (
   input  kbd_keymap_pkg::scan_code_t scan_code,
   output kbd_keymap_pkg::key_entry_t entry,
   output logic                       hit
);

   // build a key position from row and column index
   function automatic kbd_keymap_pkg::key_entry_t pos(input int row, input int col);
      kbd_keymap_pkg::key_entry_t e;
      e.row  = kbd_keymap_pkg::kbd_row_t'(row);
      e.mask = kbd_keymap_pkg::kbd_mask_t'(1 << col);
      return e;
   endfunction

   always_comb begin
      hit = 1'b1;
      case (scan_code)
         kbd_keymap_pkg::CODE_ENTER     : entry = pos(1, 7);
         kbd_keymap_pkg::CODE_AT        : entry = pos(2, 0);
         kbd_keymap_pkg::CODE_A         : entry = pos(2, 1);
         kbd_keymap_pkg::CODE_B         : entry = pos(2, 2);
         kbd_keymap_pkg::CODE_C         : entry = pos(2, 3);
         kbd_keymap_pkg::CODE_D         : entry = pos(2, 4);
         kbd_keymap_pkg::CODE_E         : entry = pos(2, 5);
         kbd_keymap_pkg::CODE_F         : entry = pos(2, 6);
         kbd_keymap_pkg::CODE_G         : entry = pos(2, 7);
         kbd_keymap_pkg::CODE_H         : entry = pos(3, 0);
         kbd_keymap_pkg::CODE_I         : entry = pos(3, 1);
         kbd_keymap_pkg::CODE_J         : entry = pos(3, 2);
         kbd_keymap_pkg::CODE_K         : entry = pos(3, 3);
         kbd_keymap_pkg::CODE_L         : entry = pos(3, 4);
         kbd_keymap_pkg::CODE_M         : entry = pos(3, 5);
         kbd_keymap_pkg::CODE_N         : entry = pos(3, 6);
         kbd_keymap_pkg::CODE_O         : entry = pos(3, 7);
         kbd_keymap_pkg::CODE_P         : entry = pos(4, 0);
         kbd_keymap_pkg::CODE_Q         : entry = pos(4, 1);
         kbd_keymap_pkg::CODE_R         : entry = pos(4, 2);
         kbd_keymap_pkg::CODE_S         : entry = pos(4, 3);
         kbd_keymap_pkg::CODE_T         : entry = pos(4, 4);
         kbd_keymap_pkg::CODE_U         : entry = pos(4, 5);
         kbd_keymap_pkg::CODE_V         : entry = pos(4, 6);
         kbd_keymap_pkg::CODE_W         : entry = pos(4, 7);
         kbd_keymap_pkg::CODE_X         : entry = pos(5, 0);
         kbd_keymap_pkg::CODE_Y         : entry = pos(5, 1);
         kbd_keymap_pkg::CODE_Z         : entry = pos(5, 2);
         kbd_keymap_pkg::CODE_LBRACKET  : entry = pos(5, 3);
         kbd_keymap_pkg::CODE_YEN       : entry = pos(5, 4);
         kbd_keymap_pkg::CODE_RBRACKET  : entry = pos(5, 5);
         kbd_keymap_pkg::CODE_CARET     : entry = pos(5, 6);
         kbd_keymap_pkg::CODE_MINUS     : entry = pos(5, 7);
         kbd_keymap_pkg::CODE_0         : entry = pos(6, 0);
         kbd_keymap_pkg::CODE_1         : entry = pos(6, 1);
         kbd_keymap_pkg::CODE_2         : entry = pos(6, 2);
         kbd_keymap_pkg::CODE_3         : entry = pos(6, 3);
         kbd_keymap_pkg::CODE_4         : entry = pos(6, 4);
         kbd_keymap_pkg::CODE_5         : entry = pos(6, 5);
         kbd_keymap_pkg::CODE_6         : entry = pos(6, 6);
         kbd_keymap_pkg::CODE_7         : entry = pos(6, 7);
         kbd_keymap_pkg::CODE_8         : entry = pos(7, 0);
         kbd_keymap_pkg::CODE_9         : entry = pos(7, 1);
         kbd_keymap_pkg::CODE_COLON     : entry = pos(7, 2);
         kbd_keymap_pkg::CODE_SEMICOLON : entry = pos(7, 3);
         kbd_keymap_pkg::CODE_COMMA     : entry = pos(7, 4);
         kbd_keymap_pkg::CODE_PERIOD    : entry = pos(7, 5);
         kbd_keymap_pkg::CODE_SLASH     : entry = pos(7, 6);
         kbd_keymap_pkg::CODE_HOME      : entry = pos(8, 0);
         kbd_keymap_pkg::CODE_DOWN      : entry = pos(8, 1);
         kbd_keymap_pkg::CODE_LEFT      : entry = pos(8, 2);
         kbd_keymap_pkg::CODE_INS       : entry = pos(8, 3);
         kbd_keymap_pkg::CODE_KANA      : entry = pos(8, 5);
         kbd_keymap_pkg::CODE_SHIFT     : entry = pos(8, 6);
         kbd_keymap_pkg::CODE_CTRL      : entry = pos(8, 7);
         kbd_keymap_pkg::CODE_STOP      : entry = pos(9, 0);
         kbd_keymap_pkg::CODE_F1        : entry = pos(9, 1);
         kbd_keymap_pkg::CODE_F2        : entry = pos(9, 2);
         kbd_keymap_pkg::CODE_F3        : entry = pos(9, 3);
         kbd_keymap_pkg::CODE_F4        : entry = pos(9, 4);
         kbd_keymap_pkg::CODE_F5        : entry = pos(9, 5);
         kbd_keymap_pkg::CODE_SPACE     : entry = pos(9, 6);
         kbd_keymap_pkg::CODE_ESC       : entry = pos(9, 7);
         default : begin   // unmapped, includes the f0 prefix
            hit   = 1'b0;
            entry = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/kbd_key_capture.sv
//********************************************************************
// key capture
// sorts strobed scan codes into break prefix, shift and mapped keys,
// holds one key until the responder releases it
//********************************************************************
`default_nettype none

module kbd_key_capture (
   input  logic                       I_CLK,
   input  logic                       I_RST,
   input  logic                       scan_strobe,
   input  kbd_keymap_pkg::key_entry_t entry,
   input  logic                       hit,
   input  kbd_keymap_pkg::scan_code_t scan_code,
   input  logic                       key_release,
   output kbd_keymap_pkg::key_entry_t held_key,
   output logic                       key_held,
   output logic                       shift_down
);

   typedef enum logic [1:0] {
      IDLE,
      AFTER_BREAK,
      HOLD
   } cap_state_t;

   cap_state_t state;
   cap_state_t state_nx;
   logic       is_break;
   logic       is_shift;
   logic       capture;    // take the decoder entry this cycle

   assign is_break = (scan_code == kbd_keymap_pkg::CODE_BREAK);
   assign is_shift = (scan_code == kbd_keymap_pkg::CODE_SHIFT);
   assign key_held = (state == HOLD);

   //*****************************************************************
   // next state
   //*****************************************************************
   always_comb begin
      state_nx = state;
      capture  = 1'b0;
      case (state)
         IDLE: begin
            if (scan_strobe) begin
               if (is_break) begin
                  state_nx = AFTER_BREAK;
               end else if (hit && !is_shift) begin
                  state_nx = HOLD;          // shift never takes the key slot
                  capture  = 1'b1;
               end
            end
         end
         AFTER_BREAK: begin
            if (scan_strobe)
               state_nx = IDLE;             // code after f0 is consumed
         end
         HOLD: begin
            if (key_release)
               state_nx = IDLE;             // strobes here are dropped
         end
         default: state_nx = IDLE;
      endcase
   end

   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         state      <= IDLE;
         shift_down <= 1'b0;
      end else begin
         state <= state_nx;
         if (scan_strobe && is_shift) begin
            if (state == IDLE)
               shift_down <= 1'b1;          // make
            else if (state == AFTER_BREAK)
               shift_down <= 1'b0;          // f0 12
         end
      end
   end

   always_ff @(posedge I_CLK) begin
      if (capture)
         held_key <= entry;
   end

   // the held position must address a real row of the matrix
   a_held_row: assert property (@(posedge I_CLK) disable iff (I_RST)
      (state == HOLD) |-> (held_key.row < kbd_keymap_pkg::NUM_ROWS));

endmodule

`default_nettype wire

//--- hdl/kbd_scan_responder.sv
//********************************************************************
// cpu scan responder
// detects port 00h reads, answers from the held key and shift flag,
// counts reads of a held key and releases it after the last one
//********************************************************************
`default_nettype none

module kbd_scan_responder (
   input  logic                       I_CLK,
   input  logic                       I_RST,
   input  kbd_bus_pkg::cpu_read_t     cpu,
   input  kbd_keymap_pkg::key_entry_t held_key,
   input  logic                       key_held,
   input  logic                       shift_down,
   output logic                       key_release,
   output kbd_bus_pkg::kbd_data_t     kbd_data
);

   logic [1:0]             iorq_sync;    // two-flop synchronizer
   logic                   iorq_prev;
   logic                   iorq_rise;
   logic                   rd_qual;      // rising iorq with port 00h
   logic                   last_read;
   logic                   row_match;
   kbd_bus_pkg::kbd_data_t shift_bits;
   kbd_bus_pkg::kbd_data_t answer;
   kbd_bus_pkg::read_cnt_t read_cnt;

   //*****************************************************************
   // iorq edge detection
   //*****************************************************************
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         iorq_sync <= 2'b00;
         iorq_prev <= 1'b0;
      end else begin
         iorq_sync <= {iorq_sync[0], cpu.iorq};
         iorq_prev <= iorq_sync[1];
      end
   end

   assign iorq_rise = iorq_sync[1] & ~iorq_prev;
   assign rd_qual   = iorq_rise & cpu.port00h;  // addr is stable by now

   //*****************************************************************
   // row answer
   //*****************************************************************
   assign last_read  = key_held &&
                       (read_cnt == kbd_bus_pkg::read_cnt_t'(kbd_bus_pkg::HELD_READS));
   assign row_match  = key_held && !last_read && (cpu.addr == held_key.row);
   assign shift_bits = (shift_down && (cpu.addr == kbd_keymap_pkg::ROW_SHIFT)) ?
                       kbd_keymap_pkg::MASK_SHIFT : '0;
   assign answer     = (row_match ? held_key.mask : '0) | shift_bits;

   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         kbd_data    <= '0;
         read_cnt    <= '0;
         key_release <= 1'b0;
      end else begin
         key_release <= 1'b0;
         if (rd_qual) begin
            kbd_data <= answer;
            if (last_read) begin
               read_cnt    <= '0;
               key_release <= 1'b1;         // capture drops the key next edge
            end else if (key_held) begin
               read_cnt <= read_cnt + 1'b1;
            end
         end
      end
   end

   a_cnt_bound: assert property (@(posedge I_CLK) disable iff (I_RST)
      read_cnt <= kbd_bus_pkg::read_cnt_t'(kbd_bus_pkg::HELD_READS));

   // release is a one-cycle pulse and the held key is gone on the next edge
   a_release_pulse: assert property (@(posedge I_CLK) disable iff (I_RST)
      key_release |=> (!key_release && !key_held));

endmodule

`default_nettype wire

//--- hdl/kbd_top.sv
//********************************************************************
// ps/2 scan code to pc-8001 key matrix converter, top level
//********************************************************************
`default_nettype none

module kbd_top (
   input  logic                       I_CLK,
   input  logic                       I_RST,
   input  logic                       scan_strobe,
   input  kbd_keymap_pkg::scan_code_t scan_code,
   input  kbd_bus_pkg::cpu_read_t     cpu,
   output kbd_bus_pkg::kbd_data_t     kbd_data
);

   kbd_keymap_pkg::key_entry_t entry;
   logic                       hit;
   kbd_keymap_pkg::key_entry_t held_key;
   logic                       key_held;
   logic                       shift_down;
   logic                       key_release;

   kbd_keymap_decoder u_decoder (
      .scan_code (scan_code),
      .entry     (entry),
      .hit       (hit)
   );

   kbd_key_capture u_capture (
      .I_CLK       (I_CLK),
      .I_RST       (I_RST),
      .scan_strobe (scan_strobe),
      .entry       (entry),
      .hit         (hit),
      .scan_code   (scan_code),
      .key_release (key_release),
      .held_key    (held_key),
      .key_held    (key_held),
      .shift_down  (shift_down)
   );

   kbd_scan_responder u_responder (
      .I_CLK       (I_CLK),
      .I_RST       (I_RST),
      .cpu         (cpu),
      .held_key    (held_key),
      .key_held    (key_held),
      .shift_down  (shift_down),
      .key_release (key_release),
      .kbd_data    (kbd_data)
   );

endmodule

`default_nettype wire

//--- bench/tb_kbd.sv
//********************************************************************
// testbench for the ps/2 to pc-8001 key matrix converter
// plays scan codes and port 00h reads from a command file and
// compares every read with the value given in that file
//********************************************************************
`default_nettype none

module tb_kbd;

   timeunit 1ns;
   timeprecision 100ps;

   localparam string STIM_FILE = "bench/kbd_stimulus.txt";
   localparam int    CLK_HALF  = 50;    // 100 ns period

   logic                       I_CLK;
   logic                       I_RST;
   logic                       scan_strobe;
   kbd_keymap_pkg::scan_code_t scan_code;
   kbd_bus_pkg::cpu_read_t     cpu;
   kbd_bus_pkg::kbd_data_t     kbd_data;

   string                  lines[$];             // one command per entry
   int                     n_lines      = 0;
   string                  test_name    = "power_on";
   int                     test_checks  = 0;
   int                     test_errors  = 0;
   int                     tests_done   = 0;
   int                     total_checks = 0;
   int                     errors       = 0;
   kbd_bus_pkg::kbd_data_t last_data    = '0;    // expected port value of the last R

   kbd_top dut (
      .I_CLK       (I_CLK),
      .I_RST       (I_RST),
      .scan_strobe (scan_strobe),
      .scan_code   (scan_code),
      .cpu         (cpu),
      .kbd_data    (kbd_data)
   );

   initial begin
      I_CLK = 1'b0;
      forever #CLK_HALF I_CLK = ~I_CLK;
   end

   // watchdog, 12 cycles per command plus room for reset
   initial begin
      wait (n_lines > 0);
      repeat (n_lines * 12 + 100) @(posedge I_CLK);
      $display("timeout: stimulus did not finish within %0d clock cycles",
               n_lines * 12 + 100);
      $display("Simulation finished: FAIL");
      $finish;
   end

   function automatic string strip_eol(input string s);
      string t;
      t = s;
      while (t.len() > 0 && (t[t.len()-1] == "\n" || t[t.len()-1] == "\r"))
         t = t.substr(0, t.len() - 2);
      return t;
   endfunction

   task automatic report_test();
      $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
      tests_done  = tests_done + 1;
      test_checks = 0;
      test_errors = 0;
   endtask

   // one strobe cycle, then three idle cycles
   task automatic press_code(input kbd_keymap_pkg::scan_code_t code);
      @(posedge I_CLK);
      scan_strobe <= 1'b1;
      scan_code   <= code;
      @(posedge I_CLK);
      scan_strobe <= 1'b0;
      repeat (3) @(posedge I_CLK);
   endtask

   //*****************************************************************
   // cpu read, iorq high 4 cycles then low 4 cycles
   //*****************************************************************
   task automatic port_read(input kbd_bus_pkg::cpu_addr_t row, input logic sel,
                            input kbd_bus_pkg::kbd_data_t expected);
      @(posedge I_CLK);
      cpu <= '{iorq: 1'b1, port00h: sel, addr: row};
      repeat (4) @(posedge I_CLK);
      cpu <= '{iorq: 1'b0, port00h: sel, addr: row};
      @(negedge I_CLK);                     // answer settled 2 cycles after sync
      test_checks  = test_checks + 1;
      total_checks = total_checks + 1;
      if (kbd_data !== expected) begin
         $display("[FAIL] time %0d ns: test %s, %s read of row %0h gave %02h, expected %02h",
                  $time, test_name, sel ? "port 00h" : "other port", row, kbd_data,
                  expected);
         test_errors = test_errors + 1;
         errors      = errors + 1;
      end
      repeat (3) @(posedge I_CLK);
   endtask

   task automatic run_line(input string line);
      kbd_bus_pkg::cpu_addr_t     row;
      kbd_bus_pkg::kbd_data_t     val;
      kbd_keymap_pkg::scan_code_t code;
      int                         n;
      n = 0;
      if (line.len() > 0 && line[0] != "#") begin
         case (line[0])
            "T": begin
               report_test();
               test_name = line.substr(2, line.len() - 1);
               n = 1;
            end
            "K": begin
               n = $sscanf(line, "K %h", code);
               if (n == 1)
                  press_code(code);
            end
            "R": begin
               n = $sscanf(line, "R %h %h", row, val);
               if (n == 2) begin
                  port_read(row, 1'b1, val);
                  last_data = val;
               end
            end
            "N": begin
               n = $sscanf(line, "N %h", row);
               if (n == 1)
                  port_read(row, 1'b0, last_data);   // port 00h value must stay
            end
            default: n = 0;
         endcase
         if (n == 0) begin
            $display("stimulus line not understood: %s", line);
            test_errors = test_errors + 1;
            errors      = errors + 1;
         end
      end
   endtask

   //*****************************************************************
   // main sequence
   //*****************************************************************
   initial begin
      int    fd;
      string line;
      I_RST       = 1'b1;
      scan_strobe = 1'b0;
      scan_code   = '0;
      cpu         = '0;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("stimulus file %s could not be opened", STIM_FILE);
         $display("Simulation finished: FAIL");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0)
               lines.push_back(strip_eol(line));
         end
         $fclose(fd);
         n_lines = lines.size();
         repeat (10) @(posedge I_CLK);
         I_RST <= 1'b0;
         @(negedge I_CLK);
         test_checks  = test_checks + 1;
         total_checks = total_checks + 1;
         if (kbd_data !== 8'h00) begin
            $display("[FAIL] time %0d ns: kbd_data after reset is %02h, expected 00",
                     $time, kbd_data);
            test_errors = test_errors + 1;
            errors      = errors + 1;
         end
         foreach (lines[i])
            run_line(lines[i]);
         report_test();
         $display("summary: %0d tests, %0d checks, %0d errors",
                  tests_done, total_checks, errors);
         if (errors == 0)
            $display("Simulation finished: PASS");
         else
            $display("Simulation finished: FAIL");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- bench/kbd_stimulus.txt
# T name | K code | R row data | N row   (code, row and data in hex)
# R reads port 00h and expects data, N reads another port, port value must not change
T idle_rows
R 0 00
R 1 00
R 2 00
R 3 00
R 4 00
R 5 00
R 6 00
R 7 00
R 8 00
R 9 00
T make_a_release
K 1C
R 0 00
R 1 00
R 2 02
N 2
N 5
R 3 00
R 4 00
R 5 00
R 6 00
R 7 00
R 8 00
R 9 00
R 0 00
R 1 00
R 2 02
R 3 00
R 2 00
R 2 00
T break_prefix
K F0
K 1C
R 2 00
T shift_flag
K 12
R 8 40
R 0 00
K F0
K 12
R 8 00
K 12
R 8 40
T unmapped_code
K 07
R 8 40
K 6C
R 8 41
R 2 00
T second_make
K 1C
R 8 41
R 2 00

//--- flist.f
hdl/kbd_keymap_pkg.sv
hdl/kbd_bus_pkg.sv
hdl/kbd_keymap_decoder.sv
hdl/kbd_key_capture.sv
hdl/kbd_scan_responder.sv
hdl/kbd_top.sv
bench/tb_kbd.sv

//--- run_sim.sh
#!/bin/sh
# build the key matrix testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_kbd -f flist.f

out=$(./obj_dir/Vtb_kbd)
echo "$out"

if echo "$out" | grep -qx "Simulation finished: PASS"; then
   exit 0
fi
exit 1
